// File: rtl/cachePkg.sv
package cachePkg;

    // cache geometry
    localparam int NUM_WAYS    = 2;
    localparam int NUM_SETS    = 4;
    localparam int INDEX_BITS  = 2;
    localparam int OFFSET_BITS = 3;
    localparam int TAG_BITS    = 59;
    localparam int LINE_BYTES  = 8;

    // width of a per-set victim pointer
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // 64-bit address split into tag, set index and byte offset
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } cacheAddr;

    // write command for one way
    typedef struct packed {
        // write this cycle
        logic                    en;
        // new line, bytes outside the mask become zero
        logic                    alloc;
        logic [INDEX_BITS-1:0]   index;
        logic [TAG_BITS-1:0]     tag;
        logic [LINE_BYTES*8-1:0] data;
        logic [LINE_BYTES-1:0]   mask;
    } wayWrite;

    // read result of one way
    typedef struct packed {
        logic                    hit;
        logic [LINE_BYTES*8-1:0] data;
    } wayLookup;

endpackage

// File: rtl/wayUpdater.sv
`timescale 1ns/1ns

module wayUpdater import cachePkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wUpdateData,
    input  logic [63:0]                  wUpdateAddress,
    input  logic [63:0]                  wActualData,
    input  logic [LINE_BYTES-1:0]        wMask,
    input  logic                         updateData,
    input  logic [63:0]                  updateAddress,
    input  logic [63:0]                  actualData,
    input  logic [NUM_WAYS-1:0]          wrMatch,
    output cacheAddr                     wrAddr,
    output wayWrite [NUM_WAYS-1:0]       wrCmd
);

    logic                    reqValid;
    logic [LINE_BYTES*8-1:0] reqData;
    logic [LINE_BYTES-1:0]   reqMask;
    logic                    anyMatch;
    logic                    allocate;
    logic [WAY_BITS-1:0]     victim;

    // round-robin victim pointer per set
    logic [WAY_BITS-1:0]     victimPtr [NUM_SETS];

    // store has priority over refill
    always_comb begin
        if (wUpdateData) begin
            reqValid = 1'b1;
            wrAddr   = cacheAddr'(wUpdateAddress);
            reqData  = wActualData;
            reqMask  = wMask;
        end else begin
            reqValid = updateData;
            wrAddr   = cacheAddr'(updateAddress);
            reqData  = actualData;
            // refill writes the whole doubleword
            reqMask  = '1;
        end
    end

    assign anyMatch = |wrMatch;
    assign allocate = reqValid && !anyMatch;
    assign victim   = victimPtr[wrAddr.index];

    // one command per way, either the hitting way or the victim
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            wrCmd[w].index = wrAddr.index;
            wrCmd[w].tag   = wrAddr.tag;
            wrCmd[w].data  = reqData;
            wrCmd[w].mask  = reqMask;
            if (anyMatch) begin
                wrCmd[w].en    = reqValid && wrMatch[w];
                wrCmd[w].alloc = 1'b0;
            end else begin
                wrCmd[w].en    = allocate && (victim == WAY_BITS'(w));
                wrCmd[w].alloc = allocate && (victim == WAY_BITS'(w));
            end
        end
    end

    // pointer only moves when a line is allocated
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                victimPtr[s] <= '0;
            end
        end else if (allocate) begin
            if (victim == WAY_BITS'(NUM_WAYS - 1)) begin
                victimPtr[wrAddr.index] <= '0;
            end else begin
                victimPtr[wrAddr.index] <= victim + 1'b1;
            end
        end
    end

endmodule

// File: rtl/cacheWay.sv
`timescale 1ns/1ns

module cacheWay import cachePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cacheAddr readAddr,
    input  cacheAddr wrAddr,
    input  wayWrite  wrCmd,
    output wayLookup readResult,
    output logic     wrMatch
);

    logic [NUM_SETS-1:0]     valid;
    logic [TAG_BITS-1:0]     tagMem  [NUM_SETS];
    logic [LINE_BYTES*8-1:0] dataMem [NUM_SETS];

    logic [LINE_BYTES*8-1:0] oldLine;
    logic [LINE_BYTES*8-1:0] newLine;

    // read port, combinational
    assign readResult.hit  = valid[readAddr.index] && (tagMem[readAddr.index] == readAddr.tag);
    assign readResult.data = dataMem[readAddr.index];

    // write-side compare, tells the updater whether this way owns the line
    assign wrMatch = valid[wrAddr.index] && (tagMem[wrAddr.index] == wrAddr.tag);

    // byte merge of the incoming data into the stored line
    always_comb begin
        oldLine = dataMem[wrCmd.index];
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (wrCmd.mask[b]) begin
                newLine[b*8 +: 8] = wrCmd.data[b*8 +: 8];
            end else if (wrCmd.alloc) begin
                // old bytes belong to the evicted tag
                newLine[b*8 +: 8] = 8'h00;
            end else begin
                newLine[b*8 +: 8] = oldLine[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wrCmd.en) begin
            valid[wrCmd.index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (wrCmd.en) begin
            tagMem[wrCmd.index]  <= wrCmd.tag;
            dataMem[wrCmd.index] <= newLine;
        end
    end

endmodule

// File: rtl/hitMerge.sv
`timescale 1ns/1ns

module hitMerge import cachePkg::*; (
    input  wayLookup [NUM_WAYS-1:0]  readResult,
    output logic                     readHit,
    output logic [LINE_BYTES*8-1:0]  readData
);

    logic [NUM_WAYS-1:0] hitVec;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hitVec[w] = readResult[w].hit;
        end
    end

    assign readHit = |hitVec;

    // walk down so the lowest hitting way is selected last
    always_comb begin
        readData = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hitVec[w]) begin
                readData = readResult[w].data;
            end
        end
    end

endmodule

// File: rtl/dataCache.sv
`timescale 1ns/1ns

module dataCache import cachePkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [63:0]           readAddress,
    output logic                  readHit,
    output logic [63:0]           readData,
    input  logic                  wUpdateData,
    input  logic [63:0]           wUpdateAddress,
    input  logic [63:0]           wActualData,
    input  logic [LINE_BYTES-1:0] wMask,
    input  logic                  updateData,
    input  logic [63:0]           updateAddress,
    input  logic [63:0]           actualData
);

    cacheAddr                readAddr;
    cacheAddr                wrAddr;
    wayWrite [NUM_WAYS-1:0]  wrCmd;
    wayLookup [NUM_WAYS-1:0] lookup;
    logic [NUM_WAYS-1:0]     wrMatch;

    assign readAddr = cacheAddr'(readAddress);

    // request steering and victim selection
    wayUpdater updater (
        .clk            (clk),
        .rst            (rst),
        .wUpdateData    (wUpdateData),
        .wUpdateAddress (wUpdateAddress),
        .wActualData    (wActualData),
        .wMask          (wMask),
        .updateData     (updateData),
        .updateAddress  (updateAddress),
        .actualData     (actualData),
        .wrMatch        (wrMatch),
        .wrAddr         (wrAddr),
        .wrCmd          (wrCmd)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : wayGen
        cacheWay wayInst (
            .clk        (clk),
            .rst        (rst),
            .readAddr   (readAddr),
            .wrAddr     (wrAddr),
            .wrCmd      (wrCmd[w]),
            .readResult (lookup[w]),
            .wrMatch    (wrMatch[w])
        );
    end

    // read hit and data from all ways
    hitMerge merge (
        .readResult (lookup),
        .readHit    (readHit),
        .readData   (readData)
    );

endmodule

// File: sim/tbDataCache.sv
`timescale 1ns/1ns

module tbDataCache import cachePkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 80;
    localparam int RANDOM_CYCLES   = 3000;
    localparam int POOL_TAGS       = 6;
    localparam int TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 2) * CLK_PERIOD + 1000;

    // one cycle of stimulus with a read plus optional store and refill
    typedef struct packed {
        cacheAddr              rdAddr;
        logic                  wEn;
        cacheAddr              wAddr;
        logic [63:0]           wData;
        logic [LINE_BYTES-1:0] wMask;
        logic                  uEn;
        cacheAddr              uAddr;
        logic [63:0]           uData;
    } request;

    logic                  clk;
    logic                  rst;
    logic [63:0]           readAddress;
    logic                  readHit;
    logic [63:0]           readData;
    logic                  wUpdateData;
    logic [63:0]           wUpdateAddress;
    logic [63:0]           wActualData;
    logic [LINE_BYTES-1:0] wMask;
    logic                  updateData;
    logic [63:0]           updateAddress;
    logic [63:0]           actualData;

    logic [31:0] lfsr = 32'h4829_3873;

    // reference model of the cache contents
    logic                mValid [NUM_WAYS][NUM_SETS];
    logic [TAG_BITS-1:0] mTag   [NUM_WAYS][NUM_SETS];
    logic [63:0]         mData  [NUM_WAYS][NUM_SETS];
    int                  mPtr   [NUM_SETS];

    dataCache UUT (
        .clk            (clk),
        .rst            (rst),
        .readAddress    (readAddress),
        .readHit        (readHit),
        .readData       (readData),
        .wUpdateData    (wUpdateData),
        .wUpdateAddress (wUpdateAddress),
        .wActualData    (wActualData),
        .wMask          (wMask),
        .updateData     (updateData),
        .updateAddress  (updateAddress),
        .actualData     (actualData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] takeBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = stepLfsr(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // small tag pool so that sets fill up and evict
    function automatic logic [TAG_BITS-1:0] poolTag(input int sel);
        return TAG_BITS'(64'h0123_4567_89AB_0000 ^ (64'(sel) * 64'h1111));
    endfunction

    function automatic cacheAddr addrOf(input int sel, input int idx);
        cacheAddr a;
        a.tag    = poolTag(sel);
        a.index  = INDEX_BITS'(idx);
        a.offset = '0;
        return a;
    endfunction

    function automatic cacheAddr randAddr();
        cacheAddr a;
        int sel;
        sel      = int'(takeBits(3)) % POOL_TAGS;
        a.tag    = poolTag(sel);
        a.index  = INDEX_BITS'(takeBits(INDEX_BITS));
        a.offset = OFFSET_BITS'(takeBits(OFFSET_BITS));
        return a;
    endfunction

    function automatic request readOnly(input cacheAddr rd);
        request r;
        r        = '0;
        r.rdAddr = rd;
        return r;
    endfunction

    task automatic modelReset();
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                mValid[w][s] = 1'b0;
                mTag[w][s]   = '0;
                mData[w][s]  = '0;
            end
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            mPtr[s] = 0;
        end
    endtask

    // lowest way that holds the tag wins and a miss reads zero
    function automatic wayLookup modelRead(input cacheAddr a);
        wayLookup res;
        res.hit  = 1'b0;
        res.data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!res.hit && mValid[w][a.index] && mTag[w][a.index] == a.tag) begin
                res.hit  = 1'b1;
                res.data = mData[w][a.index];
            end
        end
        return res;
    endfunction

    task automatic modelWrite(input cacheAddr a, input logic [63:0] d,
                              input logic [LINE_BYTES-1:0] m);
        int hitWay;
        int w;
        hitWay = -1;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (mValid[i][a.index] && mTag[i][a.index] == a.tag) begin
                hitWay = i;
            end
        end
        if (hitWay >= 0) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (m[b]) begin
                    mData[hitWay][a.index][b*8 +: 8] = d[b*8 +: 8];
                end
            end
        end else begin
            // a miss fills the round-robin victim and clears unmasked bytes
            w = mPtr[a.index];
            for (int b = 0; b < LINE_BYTES; b++) begin
                mData[w][a.index][b*8 +: 8] = m[b] ? d[b*8 +: 8] : 8'h00;
            end
            mValid[w][a.index] = 1'b1;
            mTag[w][a.index]   = a.tag;
            mPtr[a.index]      = (w + 1) % NUM_WAYS;
        end
    endtask

    task automatic checkHit(input cacheAddr a, input wayLookup exp);
        if (readHit !== exp.hit) begin
            $display("FAIL time=%0t readHit addr=%h expected=%b actual=%b",
                     $time, a, exp.hit, readHit);
            $display("test failed");
            $fatal(1, "readHit mismatch");
        end
    endtask

    task automatic checkData(input cacheAddr a, input wayLookup exp);
        if (readData !== exp.data) begin
            $display("FAIL time=%0t readData addr=%h expected=%h actual=%h",
                     $time, a, exp.data, readData);
            $display("test failed");
            $fatal(1, "readData mismatch");
        end
    endtask

    // drive at the rising edge, check mid-cycle, then let the model take the write
    task automatic runCycle(input request r);
        wayLookup exp;
        @(posedge clk);
        readAddress    <= r.rdAddr;
        wUpdateData    <= r.wEn;
        wUpdateAddress <= r.wAddr;
        wActualData    <= r.wData;
        wMask          <= r.wMask;
        updateData     <= r.uEn;
        updateAddress  <= r.uAddr;
        actualData     <= r.uData;
        @(negedge clk);
        // model still holds the old contents during the write cycle
        exp = modelRead(r.rdAddr);
        checkHit(r.rdAddr, exp);
        checkData(r.rdAddr, exp);
        if (r.wEn) begin
            modelWrite(r.wAddr, r.wData, r.wMask);
        end else if (r.uEn) begin
            modelWrite(r.uAddr, r.uData, '1);
        end
    endtask

    initial begin
        request     r;
        logic [1:0] pick;
        rst            = 1'b1;
        readAddress    = '0;
        wUpdateData    = 1'b0;
        wUpdateAddress = '0;
        wActualData    = '0;
        wMask          = '0;
        updateData     = 1'b0;
        updateAddress  = '0;
        actualData     = '0;
        modelReset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // everything misses after reset
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int t = 0; t < POOL_TAGS; t++) begin
                runCycle(readOnly(addrOf(t, s)));
            end
        end

        // refill and read back, then a second tag in the same set
        r       = readOnly(addrOf(0, 1));
        r.uEn   = 1'b1;
        r.uAddr = addrOf(0, 1);
        r.uData = 64'h1122_3344_5566_7788;
        runCycle(r);
        runCycle(readOnly(addrOf(0, 1)));
        runCycle(readOnly(addrOf(1, 1)));
        r       = readOnly(addrOf(1, 1));
        r.uEn   = 1'b1;
        r.uAddr = addrOf(1, 1);
        r.uData = 64'hCAFE_F00D_DEAD_BEEF;
        runCycle(r);
        runCycle(readOnly(addrOf(1, 1)));

        // store hit touches only the low four bytes
        r       = readOnly(addrOf(0, 1));
        r.wEn   = 1'b1;
        r.wAddr = addrOf(0, 1);
        r.wData = 64'hFFEE_DDCC_BBAA_9988;
        r.wMask = 8'h0F;
        runCycle(r);
        runCycle(readOnly(addrOf(0, 1)));

        // store misses, then two more tags in set 2 evict the first
        for (int t = 2; t < 5; t++) begin
            r       = readOnly(addrOf(2, 2));
            r.wEn   = 1'b1;
            r.wAddr = addrOf(t, 2);
            r.wData = 64'h0102_0304_0506_0708 * 64'(t);
            // mask slides so a reused way must clear its old bytes
            r.wMask = 8'h0F << (t - 2);
            runCycle(r);
            runCycle(readOnly(addrOf(2, 2)));
        end
        runCycle(readOnly(addrOf(3, 2)));
        runCycle(readOnly(addrOf(4, 2)));

        // store wins when both strobes are high
        r       = readOnly(addrOf(0, 3));
        r.wEn   = 1'b1;
        r.wAddr = addrOf(5, 3);
        r.wData = 64'hA5A5_5A5A_0F0F_F0F0;
        r.wMask = 8'hFF;
        r.uEn   = 1'b1;
        r.uAddr = addrOf(0, 3);
        r.uData = 64'h7777_8888_9999_AAAA;
        runCycle(r);
        runCycle(readOnly(addrOf(0, 3)));
        runCycle(readOnly(addrOf(5, 3)));

        // random mix against the model
        repeat (RANDOM_CYCLES) begin
            r       = '0;
            r.wEn   = takeBits(1) != 0;
            r.wAddr = randAddr();
            r.wData = takeBits(64);
            r.wMask = LINE_BYTES'(takeBits(LINE_BYTES));
            r.uEn   = takeBits(1) != 0;
            r.uAddr = randAddr();
            r.uData = takeBits(64);
            pick    = 2'(takeBits(2));
            // often read the address being written in the same cycle
            if (pick == 2'd0) begin
                r.rdAddr = r.wAddr;
            end else if (pick == 2'd1) begin
                r.rdAddr = r.uAddr;
            end else begin
                r.rdAddr = randAddr();
            end
            runCycle(r);
        end
        runCycle(readOnly(randAddr()));

        $display("test passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

// File: project.f
rtl/cachePkg.sv
rtl/wayUpdater.sv
rtl/cacheWay.sv
rtl/hitMerge.sv
rtl/dataCache.sv
sim/tbDataCache.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

rm -rf "$BUILD"

verilator --binary --timing -j 0 \
    --top-module tbDataCache \
    -Mdir "$BUILD" \
    -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/VtbDataCache" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

exit 0
